// File: hw/channel_map.sv
//--------------------
// Physical to virtual channel table
// All entries come out of reset disabled
// A write is seen by tags from the next cycle on
//--------------------
`timescale 1ns/1ps
`include "comb_cfg.svh"

module channel_map (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 capture_en_i,
    input  logic                 tag_valid_i,
    input  comb_pkg::phys_ch_t   tag_channel_i,
    input  comb_pkg::tag_time_t  tag_time_i,
    input  logic                 map_we_i,
    input  comb_pkg::phys_ch_t   map_addr_i,
    input  comb_pkg::virt_ch_t   map_virt_i,
    input  logic                 map_en_i,
    output logic                 mapped_valid_o,
    output comb_pkg::virt_ch_t   mapped_ch_o,
    output comb_pkg::tag_time_t  mapped_time_o
);

    localparam int MAP_SIZE = 2 ** `COMB_PHYS_WIDTH;

    // Virtual channel per input, plus its enable bit
    comb_pkg::virt_ch_t virt_tbl [MAP_SIZE];
    logic [MAP_SIZE-1:0] en_tbl;

    always_ff @(posedge clk) begin
        if (map_we_i) begin
            virt_tbl[map_addr_i] <= map_virt_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            en_tbl <= '0;
        end else if (map_we_i) begin
            en_tbl[map_addr_i] <= map_en_i;
        end
    end

    // Accept only enabled channels while capturing
    always_ff @(posedge clk) begin
        if (rst_i) begin
            mapped_valid_o <= 1'b0;
        end else begin
            mapped_valid_o <= tag_valid_i && capture_en_i && en_tbl[tag_channel_i];
        end
    end

    // Translated tag, one register stage
    always_ff @(posedge clk) begin
        mapped_ch_o   <= virt_tbl[tag_channel_i];
        mapped_time_o <= tag_time_i;
    end

endmodule

// File: hw/coincidence_builder.sv
//--------------------
// Groups tags inside a window that starts at the group's first tag
// An open group is emitted only when a later tag closes it
// Tag times must not decrease
//--------------------
`timescale 1ns/1ps
`include "comb_cfg.svh"

module coincidence_builder (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 clear_i,
    input  comb_pkg::tag_time_t  window_i,
    input  comb_pkg::mult_t      filter_min_i,
    input  comb_pkg::mult_t      filter_max_i,
    input  logic                 mapped_valid_i,
    input  comb_pkg::virt_ch_t   mapped_ch_i,
    input  comb_pkg::tag_time_t  mapped_time_i,
    output logic                 comb_valid_o,
    output comb_pkg::comb_bits_t comb_bits_o
);

    logic                 open_q;
    comb_pkg::tag_time_t  start_q;
    comb_pkg::comb_bits_t bits_q;
    comb_pkg::comb_bits_t ch_bit;
    comb_pkg::tag_time_t  elapsed;
    comb_pkg::mult_t      bit_count;
    logic                 start_group;
    logic                 in_range;

    assign ch_bit  = comb_pkg::comb_bits_t'(1) << mapped_ch_i;
    // Wraps cleanly since times only grow
    assign elapsed = mapped_time_i - start_q;

    // New group on the first tag, or on a tag past the window
    assign start_group = mapped_valid_i && (!open_q || (elapsed > window_i));

    // Multiplicity of the group being closed
    always_comb begin
        bit_count = '0;
        for (int i = 0; i < `COMB_CHANNELS; i++) begin
            bit_count = bit_count + comb_pkg::mult_t'(bits_q[i]);
        end
    end

    assign in_range = (bit_count >= filter_min_i) && (bit_count <= filter_max_i);

    always_ff @(posedge clk) begin
        if (rst_i || clear_i) begin
            open_q       <= 1'b0;
            comb_valid_o <= 1'b0;
        end else begin
            open_q       <= open_q || mapped_valid_i;
            // One-cycle pulse for a closed group that passes the filter
            comb_valid_o <= start_group && open_q && in_range;
        end
    end

    // Window start and accumulated bits
    always_ff @(posedge clk) begin
        if (start_group) begin
            start_q     <= mapped_time_i;
            bits_q      <= ch_bit;
            comb_bits_o <= bits_q;
        end else if (mapped_valid_i) begin
            bits_q <= bits_q | ch_bit;
        end
    end

endmodule

// File: hw/comb_cfg.svh
//--------------------
// Sizes shared by every block of the coincidence detector
// Histogram holds 2**COMB_CHANNELS entries, so keep COMB_CHANNELS small
// COMB_FIFO_DEPTH must be a power of two
//--------------------
`ifndef COMB_CFG_SVH
`define COMB_CFG_SVH

// Virtual channels, one bit each in a bitset
`define COMB_CHANNELS   4
// Physical channel number width, 16 inputs
`define COMB_PHYS_WIDTH 4
`define COMB_VIRT_WIDTH 2
`define COMB_TIME_WIDTH 32
// Must hold the value COMB_CHANNELS
`define COMB_MULT_WIDTH 3
`define COMB_ACC_WIDTH  16
`define COMB_FIFO_DEPTH 8

`endif

// File: hw/comb_histogram.sv
//--------------------
// One saturating counter per bitset value
// Clear sweep takes one cycle per entry, readout walks entries in order
// Increments outside idle are lost
//--------------------
`timescale 1ns/1ps
`include "comb_cfg.svh"

module comb_histogram (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 clear_i,
    input  logic                 inc_valid_i,
    input  comb_pkg::comb_bits_t inc_bits_i,
    input  logic                 read_start_i,
    input  logic                 read_ready_i,
    output logic                 clear_done_o,
    output logic                 read_valid_o,
    output comb_pkg::comb_bits_t read_index_o,
    output comb_pkg::acc_t       read_count_o
);

    localparam int HIST_SIZE = 2 ** `COMB_CHANNELS;

    comb_pkg::hist_state_e state;
    // Shared pointer for the sweep and the readout
    comb_pkg::comb_bits_t  idx;
    comb_pkg::acc_t        cnt [HIST_SIZE];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state <= comb_pkg::HIST_IDLE;
            idx   <= '0;
            // Counters zeroed in place, no sweep needed
            for (int i = 0; i < HIST_SIZE; i++) begin
                cnt[i] <= '0;
            end
        end else if (clear_i) begin
            state <= comb_pkg::HIST_CLEAR;
            idx   <= '0;
        end else begin
            case (state)
                comb_pkg::HIST_IDLE: begin
                    // Saturate at all ones
                    if (inc_valid_i && (cnt[inc_bits_i] != '1)) begin
                        cnt[inc_bits_i] <= cnt[inc_bits_i] + 1'b1;
                    end
                    if (read_start_i) begin
                        state <= comb_pkg::HIST_READ;
                        idx   <= '0;
                    end
                end
                comb_pkg::HIST_CLEAR: begin
                    cnt[idx] <= '0;
                    idx      <= idx + 1'b1;
                    if (idx == '1) begin
                        state <= comb_pkg::HIST_IDLE;
                    end
                end
                comb_pkg::HIST_READ: begin
                    // Hold the entry until the reader takes it
                    if (read_ready_i) begin
                        idx <= idx + 1'b1;
                        if (idx == '1) begin
                            state <= comb_pkg::HIST_IDLE;
                        end
                    end
                end
                default: begin
                    state <= comb_pkg::HIST_IDLE;
                end
            endcase
        end
    end

    assign clear_done_o = (state != comb_pkg::HIST_CLEAR);
    assign read_valid_o = (state == comb_pkg::HIST_READ);
    assign read_index_o = idx;
    assign read_count_o = cnt[idx];

endmodule

// File: hw/comb_pkg.sv
//--------------------
// Types for the coincidence detector
// Widths follow comb_cfg.svh
//--------------------
`include "comb_cfg.svh"

package comb_pkg;

    typedef logic [`COMB_CHANNELS-1:0]   comb_bits_t;
    typedef logic [`COMB_TIME_WIDTH-1:0] tag_time_t;
    typedef logic [`COMB_PHYS_WIDTH-1:0] phys_ch_t;
    typedef logic [`COMB_VIRT_WIDTH-1:0] virt_ch_t;
    typedef logic [`COMB_MULT_WIDTH-1:0] mult_t;
    typedef logic [`COMB_ACC_WIDTH-1:0]  acc_t;

    // Output routing of finished groups
    typedef enum logic [1:0] {MODE_OFF, MODE_STREAM, MODE_HIST} comb_mode_e;

    // Histogram FSM
    typedef enum logic [1:0] {HIST_IDLE, HIST_CLEAR, HIST_READ} hist_state_e;

endpackage

// File: hw/comb_top.sv
//--------------------
// Coincidence detector, one tag per clock, no back-pressure on tags
// Config levels must only change with no tags in flight
//--------------------
`timescale 1ns/1ps

module comb_top (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 clear_i,
    input  logic                 capture_en_i,
    input  comb_pkg::comb_mode_e mode_i,
    input  comb_pkg::tag_time_t  window_i,
    input  comb_pkg::mult_t      filter_min_i,
    input  comb_pkg::mult_t      filter_max_i,
    input  logic                 tag_valid_i,
    input  comb_pkg::phys_ch_t   tag_channel_i,
    input  comb_pkg::tag_time_t  tag_time_i,
    input  logic                 map_we_i,
    input  comb_pkg::phys_ch_t   map_addr_i,
    input  comb_pkg::virt_ch_t   map_virt_i,
    input  logic                 map_en_i,
    input  logic                 stream_ready_i,
    input  logic                 read_start_i,
    input  logic                 read_ready_i,
    output logic                 stream_valid_o,
    output comb_pkg::comb_bits_t stream_bits_o,
    output logic                 overflow_o,
    output logic                 clear_done_o,
    output logic                 read_valid_o,
    output comb_pkg::comb_bits_t read_index_o,
    output comb_pkg::acc_t       read_count_o
);

    logic                 mapped_valid;
    comb_pkg::virt_ch_t   mapped_ch;
    comb_pkg::tag_time_t  mapped_time;
    logic                 comb_valid;
    comb_pkg::comb_bits_t comb_bits;
    logic                 fifo_push;
    logic                 hist_inc;

    channel_map map0 (
        .clk            (clk),
        .rst_i          (rst_i),
        .capture_en_i   (capture_en_i),
        .tag_valid_i    (tag_valid_i),
        .tag_channel_i  (tag_channel_i),
        .tag_time_i     (tag_time_i),
        .map_we_i       (map_we_i),
        .map_addr_i     (map_addr_i),
        .map_virt_i     (map_virt_i),
        .map_en_i       (map_en_i),
        .mapped_valid_o (mapped_valid),
        .mapped_ch_o    (mapped_ch),
        .mapped_time_o  (mapped_time)
    );

    coincidence_builder builder0 (
        .clk            (clk),
        .rst_i          (rst_i),
        .clear_i        (clear_i),
        .window_i       (window_i),
        .filter_min_i   (filter_min_i),
        .filter_max_i   (filter_max_i),
        .mapped_valid_i (mapped_valid),
        .mapped_ch_i    (mapped_ch),
        .mapped_time_i  (mapped_time),
        .comb_valid_o   (comb_valid),
        .comb_bits_o    (comb_bits)
    );

    // Mode picks the consumer, MODE_OFF drops groups
    assign fifo_push = comb_valid && (mode_i == comb_pkg::MODE_STREAM);
    assign hist_inc  = comb_valid && (mode_i == comb_pkg::MODE_HIST);

    stream_fifo fifo0 (
        .clk         (clk),
        .rst_i       (rst_i),
        .clear_i     (clear_i),
        .push_i      (fifo_push),
        .push_bits_i (comb_bits),
        .pop_ready_i (stream_ready_i),
        .valid_o     (stream_valid_o),
        .bits_o      (stream_bits_o),
        .overflow_o  (overflow_o)
    );

    comb_histogram hist0 (
        .clk          (clk),
        .rst_i        (rst_i),
        .clear_i      (clear_i),
        .inc_valid_i  (hist_inc),
        .inc_bits_i   (comb_bits),
        .read_start_i (read_start_i),
        .read_ready_i (read_ready_i),
        .clear_done_o (clear_done_o),
        .read_valid_o (read_valid_o),
        .read_index_o (read_index_o),
        .read_count_o (read_count_o)
    );

endmodule

// File: hw/stream_fifo.sv
//--------------------
// First-word-fall-through FIFO for streamed bitsets
// A push into a full FIFO is lost and sets a sticky overflow flag
//--------------------
`timescale 1ns/1ps
`include "comb_cfg.svh"

module stream_fifo (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 clear_i,
    input  logic                 push_i,
    input  comb_pkg::comb_bits_t push_bits_i,
    input  logic                 pop_ready_i,
    output logic                 valid_o,
    output comb_pkg::comb_bits_t bits_o,
    output logic                 overflow_o
);

    localparam int PTR_W = $clog2(`COMB_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`COMB_FIFO_DEPTH + 1);

    comb_pkg::comb_bits_t mem [`COMB_FIFO_DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     count;
    logic                 full;
    logic                 do_push;
    logic                 do_pop;

    assign full    = (count == CNT_W'(`COMB_FIFO_DEPTH));
    assign do_push = push_i && !full;
    assign do_pop  = valid_o && pop_ready_i;

    always_ff @(posedge clk) begin
        if (rst_i || clear_i) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            overflow_o <= 1'b0;
        end else begin
            // Pointers wrap on their own, depth is a power of two
            wr_ptr     <= wr_ptr + PTR_W'(do_push);
            rd_ptr     <= rd_ptr + PTR_W'(do_pop);
            count      <= count + CNT_W'(do_push) - CNT_W'(do_pop);
            overflow_o <= overflow_o || (push_i && full);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_bits_i;
        end
    end

    // Head word shows without a read request
    assign valid_o = (count != '0);
    assign bits_o  = mem[rd_ptr];

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it into sim.log and
# decides pass or fail from the log
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        -f sources.f --top-module comb_tb -o comb_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/comb_sim > "$LOG" 2>&1; then
    echo "Simulation exited with an error status"
fi
cat "$LOG"

if grep -qx '>>> PASS' "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi

// File: sources.f
+incdir+hw
hw/comb_pkg.sv
hw/channel_map.sv
hw/coincidence_builder.sv
hw/comb_histogram.sv
hw/stream_fifo.sv
hw/comb_top.sv
verif/comb_properties.sv
verif/comb_tb.sv

// File: verif/comb_properties.sv
//--------------------
// Concurrent checks on comb_top outputs, attached by bind
// hist_state_i taps the histogram FSM inside comb_top
//--------------------
`timescale 1ns/1ps

module comb_properties (
    input logic                  clk,
    input logic                  rst_i,
    input logic                  clear_i,
    input logic                  stream_ready_i,
    input logic                  read_ready_i,
    input logic                  stream_valid_i,
    input comb_pkg::comb_bits_t  stream_bits_i,
    input logic                  overflow_i,
    input logic                  clear_done_i,
    input logic                  read_valid_i,
    input comb_pkg::comb_bits_t  read_index_i,
    input comb_pkg::hist_state_e hist_state_i
);

    // No readout while the sweep runs
    assert property (@(posedge clk) disable iff (rst_i) !(read_valid_i && !clear_done_i))
        else $error("read_valid_o high while clear_done_o low");

    // Stream head holds under back-pressure
    assert property (@(posedge clk) disable iff (rst_i)
        (stream_valid_i && !stream_ready_i && !clear_i) |=>
            (stream_valid_i && $stable(stream_bits_i)))
        else $error("stream output changed while stalled");

    assert property (@(posedge clk) disable iff (rst_i)
        (read_valid_i && !read_ready_i && !clear_i) |=>
            (read_valid_i && $stable(read_index_i)))
        else $error("read index changed while stalled");

    // Sticky flag
    assert property (@(posedge clk) disable iff (rst_i)
        (overflow_i && !clear_i) |=> overflow_i)
        else $error("overflow_o fell without clear or reset");

    assert property (@(posedge clk) disable iff (rst_i)
        (hist_state_i != comb_pkg::HIST_READ) |-> !read_valid_i)
        else $error("read_valid_o high outside the read state");

endmodule

bind comb_top comb_properties props0 (
    .clk            (clk),
    .rst_i          (rst_i),
    .clear_i        (clear_i),
    .stream_ready_i (stream_ready_i),
    .read_ready_i   (read_ready_i),
    .stream_valid_i (stream_valid_o),
    .stream_bits_i  (stream_bits_o),
    .overflow_i     (overflow_o),
    .clear_done_i   (clear_done_o),
    .read_valid_i   (read_valid_o),
    .read_index_i   (read_index_o),
    .hist_state_i   (hist0.state)
);

// File: verif/comb_tb.sv
//--------------------
// Directed tests for comb_top with one task per behavior
// Expected values come from a model of the map, window and filter rules
// Tests run in a fixed order and share tag time and model state
//--------------------
`timescale 1ns/1ps
`include "comb_cfg.svh"

module comb_tb;

    localparam int MAX_CYCLES = 20000;
    localparam int MAP_SIZE   = 2 ** `COMB_PHYS_WIDTH;
    localparam int HIST_SIZE  = 2 ** `COMB_CHANNELS;

    logic                 clk;
    logic                 rst_i;
    logic                 clear_i;
    logic                 capture_en_i;
    comb_pkg::comb_mode_e mode_i;
    comb_pkg::tag_time_t  window_i;
    comb_pkg::mult_t      filter_min_i;
    comb_pkg::mult_t      filter_max_i;
    logic                 tag_valid_i;
    comb_pkg::phys_ch_t   tag_channel_i;
    comb_pkg::tag_time_t  tag_time_i;
    logic                 map_we_i;
    comb_pkg::phys_ch_t   map_addr_i;
    comb_pkg::virt_ch_t   map_virt_i;
    logic                 map_en_i;
    logic                 stream_ready_i;
    logic                 read_start_i;
    logic                 read_ready_i;
    logic                 stream_valid_o;
    comb_pkg::comb_bits_t stream_bits_o;
    logic                 overflow_o;
    logic                 clear_done_o;
    logic                 read_valid_o;
    comb_pkg::comb_bits_t read_index_o;
    comb_pkg::acc_t       read_count_o;

    // Model of map table, open group and histogram
    comb_pkg::virt_ch_t   model_virt [MAP_SIZE];
    logic                 model_en [MAP_SIZE];
    logic                 model_open;
    comb_pkg::tag_time_t  model_start;
    comb_pkg::comb_bits_t model_bits;
    int                   tally [HIST_SIZE];
    comb_pkg::comb_bits_t exp_q [$];
    comb_pkg::comb_bits_t got_q [$];
    comb_pkg::tag_time_t  now_time;
    logic [31:0]          rng_state;
    int                   cycle_count = 0;

    comb_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display(">>> FAIL");
            $fatal(1, "run timed out");
        end
    end

    // Every word taken off the stream port
    always @(posedge clk) begin
        if (!rst_i && stream_valid_o && stream_ready_i) begin
            got_q.push_back(stream_bits_o);
        end
    end

    task automatic report_failure(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display(">>> FAIL");
        $fatal(1, "stopping at first failed check");
    endtask

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic int count_bits(input comb_pkg::comb_bits_t bits);
        int n;
        n = 0;
        for (int i = 0; i < `COMB_CHANNELS; i++) begin
            n = n + int'(bits[i]);
        end
        return n;
    endfunction

    // Closed group passes the inclusive filter and is routed by mode
    function automatic void close_group(input comb_pkg::comb_bits_t bits);
        int n;
        n = count_bits(bits);
        if (n >= int'(filter_min_i) && n <= int'(filter_max_i)) begin
            if (mode_i == comb_pkg::MODE_STREAM) begin
                exp_q.push_back(bits);
            end else if (mode_i == comb_pkg::MODE_HIST) begin
                tally[bits] = tally[bits] + 1;
            end
        end
    endfunction

    function automatic void predict_tag(input int ch, input comb_pkg::tag_time_t t);
        comb_pkg::comb_bits_t b;
        b = comb_pkg::comb_bits_t'(1) << model_virt[ch];
        if (capture_en_i && model_en[ch]) begin
            if (!model_open) begin
                model_open  = 1'b1;
                model_start = t;
                model_bits  = b;
            end else if (t - model_start > window_i) begin
                close_group(model_bits);
                model_start = t;
                model_bits  = b;
            end else begin
                model_bits = model_bits | b;
            end
        end
    endfunction

    // One tag dt after the previous one
    task automatic send_tag(input int ch, input int dt);
        @(posedge clk);
        now_time = now_time + comb_pkg::tag_time_t'(dt);
        tag_valid_i   <= 1'b1;
        tag_channel_i <= comb_pkg::phys_ch_t'(ch);
        tag_time_i    <= now_time;
        predict_tag(ch, now_time);
        @(posedge clk);
        tag_valid_i <= 1'b0;
    endtask

    task automatic write_map(input int addr, input int virt, input logic en);
        @(posedge clk);
        map_we_i   <= 1'b1;
        map_addr_i <= comb_pkg::phys_ch_t'(addr);
        map_virt_i <= comb_pkg::virt_ch_t'(virt);
        map_en_i   <= en;
        model_virt[addr] = comb_pkg::virt_ch_t'(virt);
        model_en[addr]   = en;
        @(posedge clk);
        map_we_i <= 1'b0;
    endtask

    task automatic configure(input logic cap, input comb_pkg::comb_mode_e mode,
                             input int win, input int fmin, input int fmax);
        @(posedge clk);
        capture_en_i <= cap;
        mode_i       <= mode;
        window_i     <= comb_pkg::tag_time_t'(win);
        filter_min_i <= comb_pkg::mult_t'(fmin);
        filter_max_i <= comb_pkg::mult_t'(fmax);
    endtask

    task automatic set_stream_ready(input logic ready);
        @(posedge clk);
        stream_ready_i <= ready;
    endtask

    // Map stage and builder stage and one cycle for the counter update
    task automatic settle();
        repeat (4) @(posedge clk);
    endtask

    // Pulse clear and count the cycles clear_done_o stays low
    task automatic clear_and_wait(output int low_cycles);
        @(posedge clk);
        clear_i <= 1'b1;
        @(posedge clk);
        clear_i <= 1'b0;
        low_cycles = 0;
        do begin
            @(posedge clk);
            if (!clear_done_o) begin
                low_cycles++;
            end
        end while (!clear_done_o);
        model_open = 1'b0;
        for (int i = 0; i < HIST_SIZE; i++) begin
            tally[i] = 0;
        end
        exp_q.delete();
        got_q.delete();
    endtask

    task automatic collect_stream();
        int guard;
        guard = 0;
        do begin
            @(posedge clk);
            guard++;
        end while ((guard < 4 || got_q.size() < exp_q.size() || stream_valid_o)
                   && guard < 200);
    endtask

    task automatic compare_stream(input string name);
        assert (got_q.size() == exp_q.size()) else report_failure($sformatf(
            "%s: %0d words streamed, expected %0d", name, got_q.size(), exp_q.size()));
        foreach (exp_q[i]) begin
            assert (got_q[i] == exp_q[i]) else report_failure($sformatf(
                "%s: word %0d is %b, expected %b", name, i, got_q[i], exp_q[i]));
        end
    endtask

    // Ordered readout with random back-pressure
    task automatic read_and_compare(input string name);
        int idx;
        logic [31:0] rnd;
        idx = 0;
        @(posedge clk);
        read_start_i <= 1'b1;
        read_ready_i <= 1'b0;
        @(posedge clk);
        read_start_i <= 1'b0;
        while (idx < HIST_SIZE) begin
            @(posedge clk);
            if (read_valid_o && read_ready_i) begin
                assert (int'(read_index_o) == idx) else report_failure($sformatf(
                    "%s: read index %0d, expected %0d", name, read_index_o, idx));
                assert (int'(read_count_o) == tally[idx]) else report_failure($sformatf(
                    "%s: count %0d at entry %0d, expected %0d",
                    name, read_count_o, idx, tally[idx]));
                idx++;
            end
            rnd = next_random();
            read_ready_i <= rnd[0];
        end
        read_ready_i <= 1'b0;
        @(posedge clk);
        assert (!read_valid_o) else report_failure($sformatf(
            "%s: read_valid_o still high after entry 15", name));
    endtask

    task automatic group_stream_tags();
        int lows;
        clear_and_wait(lows);
        configure(1'b1, comb_pkg::MODE_STREAM, 10, 1, 4);
        for (int i = 0; i < 4; i++) begin
            write_map(i, i, 1'b1);
        end
        write_map(5, 1, 1'b1);
        send_tag(0, 100);
        send_tag(1, 3);
        send_tag(2, 4);
        send_tag(3, 20);
        // Exactly at the window edge stays inside
        send_tag(5, 10);
        send_tag(2, 11);
        send_tag(2, 0);
        send_tag(0, 30);
        send_tag(3, 50);
        collect_stream();
        compare_stream("grouping");
    endtask

    task automatic filter_multiplicity();
        int lows;
        int sizes [6];
        sizes = '{1, 2, 3, 4, 2, 1};
        clear_and_wait(lows);
        configure(1'b1, comb_pkg::MODE_STREAM, 10, 2, 3);
        foreach (sizes[g]) begin
            for (int c = 0; c < sizes[g]; c++) begin
                send_tag(c, (c == 0) ? 50 : 1);
            end
        end
        send_tag(0, 50);
        collect_stream();
        compare_stream("filter");
    endtask

    task automatic gate_map_and_capture();
        int lows;
        clear_and_wait(lows);
        configure(1'b1, comb_pkg::MODE_STREAM, 10, 1, 4);
        write_map(5, 1, 1'b0);
        write_map(6, 2, 1'b0);
        send_tag(0, 100);
        send_tag(6, 1);
        send_tag(1, 1);
        // Tags while capture is off leave no trace
        configure(1'b0, comb_pkg::MODE_STREAM, 10, 1, 4);
        send_tag(2, 50);
        send_tag(3, 1);
        configure(1'b1, comb_pkg::MODE_STREAM, 10, 1, 4);
        send_tag(3, 50);
        send_tag(5, 1);
        send_tag(0, 50);
        collect_stream();
        compare_stream("gating");
    endtask

    // Open group left by the overflow test carries over into the tally
    task automatic fill_and_read_histogram();
        logic [31:0] rnd;
        configure(1'b1, comb_pkg::MODE_HIST, 8, 1, 4);
        for (int i = 0; i < 80; i++) begin
            rnd = next_random();
            send_tag(int'(rnd[1:0]), int'(rnd[7:4]));
        end
        send_tag(0, 100);
        settle();
        read_and_compare("histogram");
    endtask

    // Histogram holds counts and overflow_o is still set from earlier tests
    task automatic clear_and_read_back();
        int lows;
        clear_and_wait(lows);
        assert (lows == HIST_SIZE) else report_failure($sformatf(
            "clear: clear_done_o low for %0d cycles, expected %0d", lows, HIST_SIZE));
        read_and_compare("clear");
        assert (!overflow_o) else report_failure("clear: overflow_o high");
    endtask

    task automatic overflow_stream_fifo();
        int lows;
        int guard;
        clear_and_wait(lows);
        configure(1'b1, comb_pkg::MODE_STREAM, 5, 1, 4);
        set_stream_ready(1'b0);
        // Eleven single tags close ten groups
        for (int i = 0; i <= 10; i++) begin
            send_tag(i % 4, 20);
        end
        guard = 0;
        do begin
            @(posedge clk);
            guard++;
        end while (!overflow_o && guard < 20);
        assert (overflow_o) else report_failure("overflow: overflow_o stayed low");
        while (exp_q.size() > `COMB_FIFO_DEPTH) begin
            void'(exp_q.pop_back());
        end
        set_stream_ready(1'b1);
        collect_stream();
        compare_stream("overflow");
        assert (overflow_o) else report_failure("overflow: flag fell without clear");
    endtask

    initial begin
        rst_i          <= 1'b1;
        clear_i        <= 1'b0;
        capture_en_i   <= 1'b0;
        mode_i         <= comb_pkg::MODE_OFF;
        window_i       <= '0;
        filter_min_i   <= '0;
        filter_max_i   <= '0;
        tag_valid_i    <= 1'b0;
        tag_channel_i  <= '0;
        tag_time_i     <= '0;
        map_we_i       <= 1'b0;
        map_addr_i     <= '0;
        map_virt_i     <= '0;
        map_en_i       <= 1'b0;
        stream_ready_i <= 1'b1;
        read_start_i   <= 1'b0;
        read_ready_i   <= 1'b0;
        for (int i = 0; i < MAP_SIZE; i++) begin
            model_virt[i] = '0;
            model_en[i]   = 1'b0;
        end
        model_open = 1'b0;
        now_time   = '0;
        rng_state  = 32'hbc5a;
        repeat (5) @(posedge clk);
        rst_i <= 1'b0;
        group_stream_tags();
        filter_multiplicity();
        gate_map_and_capture();
        overflow_stream_fifo();
        fill_and_read_histogram();
        clear_and_read_back();
        $display(">>> PASS");
        $finish;
    end

endmodule
